// File: common/lsu_pkg.sv
// Load/store unit shared definitions

package lsu_pkg;

   // ========================================================================
   // Widths
   // ========================================================================

   // Data and address width
   parameter int XLEN = 32;

   // Register index, wide enough for the full RV32 register space
   typedef logic [4:0] reg_idx_t;

   // ========================================================================
   // Memory opcodes
   // ========================================================================

   typedef enum logic [2:0] {
      MEM_LB,
      MEM_LH,
      MEM_LW,
      MEM_LBU,
      MEM_LHU,
      MEM_SB,
      MEM_SH,
      MEM_SW
   } mem_op_e;

   // ========================================================================
   // AHB transfer size
   // ========================================================================

   // Encoded as on the HSIZE bus field
   typedef enum logic [2:0] {
      HSIZE_BYTE = 3'd0,
      HSIZE_HALF = 3'd1,
      HSIZE_WORD = 3'd2
   } hsize_e;

endpackage

// File: design/regfile.sv
// Integer register file

`timescale 1ns/1ps

module regfile #(
   parameter int NUM_REGS = 32
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  lsu_pkg::reg_idx_t         raddr_a,
   input  lsu_pkg::reg_idx_t         raddr_b,
   input  logic                      we1,
   input  lsu_pkg::reg_idx_t         waddr1,
   input  logic [lsu_pkg::XLEN-1:0]  wdata1,
   input  logic                      we2,
   input  lsu_pkg::reg_idx_t         waddr2,
   input  logic [lsu_pkg::XLEN-1:0]  wdata2,
   output logic [lsu_pkg::XLEN-1:0]  rdata_a,
   output logic [lsu_pkg::XLEN-1:0]  rdata_b
);

   import lsu_pkg::*;

   logic [XLEN-1:0] regs [NUM_REGS];

   // Entry 0 is cleared on reset and never written, so x0 reads as zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         for (int i = 1; i < NUM_REGS; i++) begin
            // Load return port takes priority on a collision
            if (we2 && waddr2 == reg_idx_t'(i)) begin
               regs[i] <= wdata2;
            end else if (we1 && waddr1 == reg_idx_t'(i)) begin
               regs[i] <= wdata1;
            end
         end
      end
   end

   // Reads from stored state only, indices past NUM_REGS give zero
   assign rdata_a = (raddr_a < NUM_REGS) ? regs[raddr_a] : '0;
   assign rdata_b = (raddr_b < NUM_REGS) ? regs[raddr_b] : '0;

endmodule

// File: lsu/lsu_request.sv
// Data bus address phase and store data

`timescale 1ns/1ps

module lsu_request (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      op_valid,
   input  logic                      interlock,
   input  lsu_pkg::mem_op_e          mem_op,
   input  logic [11:0]               imm12,
   input  logic [lsu_pkg::XLEN-1:0]  base_data,
   input  logic [lsu_pkg::XLEN-1:0]  store_data,
   input  logic [lsu_pkg::XLEN-1:0]  load_data,
   input  logic                      fwd_store,
   input  logic                      hready,
   output logic [lsu_pkg::XLEN-1:0]  haddr,
   output lsu_pkg::hsize_e           hsize,
   output logic                      htrans,
   output logic                      hwrite,
   output logic [lsu_pkg::XLEN-1:0]  hwdata
);

   import lsu_pkg::*;

   logic [XLEN-1:0] offset_sext;
   logic            is_store;
   logic [XLEN-1:0] src_data;
   logic [XLEN-1:0] wdata_placed;

   // ========================================================================
   // Address phase
   // ========================================================================

   assign offset_sext = {{(XLEN-12){imm12[11]}}, imm12};
   assign haddr       = base_data + offset_sext;

   // Opcode to size and direction
   always_comb begin
      case (mem_op)
         MEM_LB, MEM_LBU: begin
            hsize    = HSIZE_BYTE;
            is_store = 1'b0;
         end
         MEM_LH, MEM_LHU: begin
            hsize    = HSIZE_HALF;
            is_store = 1'b0;
         end
         MEM_SB: begin
            hsize    = HSIZE_BYTE;
            is_store = 1'b1;
         end
         MEM_SH: begin
            hsize    = HSIZE_HALF;
            is_store = 1'b1;
         end
         MEM_SW: begin
            hsize    = HSIZE_WORD;
            is_store = 1'b1;
         end
         default: begin
            hsize    = HSIZE_WORD;
            is_store = 1'b0;
         end
      endcase
   end

   // No transfer is put out while the base register is still in flight
   assign htrans = op_valid & ~interlock;
   assign hwrite = htrans & is_store;

   // ========================================================================
   // Store lane placement
   // ========================================================================

   // Returning load data bypasses the register file for a back-to-back store
   assign src_data = fwd_store ? load_data : store_data;

   // Unused lanes go out as zero
   always_comb begin
      case (hsize)
         HSIZE_BYTE: begin
            wdata_placed = {24'h0, src_data[7:0]} << {haddr[1:0], 3'b000};
         end
         HSIZE_HALF: begin
            if (haddr[1]) begin
               wdata_placed = {src_data[15:0], 16'h0};
            end else begin
               wdata_placed = {16'h0, src_data[15:0]};
            end
         end
         default: begin
            wdata_placed = src_data;
         end
      endcase
   end

   // Data phase follows the accepted address phase by one edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hwdata <= '0;
      end else if (htrans && hready) begin
         hwdata <= wdata_placed;
      end
   end

endmodule

// File: lsu/lsu_load_return.sv
// Load data phase, write-back and interlock

`timescale 1ns/1ps

module lsu_load_return (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      htrans,
   input  logic                      hwrite,
   input  logic                      hready,
   input  lsu_pkg::mem_op_e          mem_op,
   input  lsu_pkg::reg_idx_t         rd,
   input  lsu_pkg::reg_idx_t         rs1,
   input  lsu_pkg::reg_idx_t         rs2,
   input  logic [1:0]                addr_lo,
   input  logic [lsu_pkg::XLEN-1:0]  hrdata,
   output logic                      load_we,
   output lsu_pkg::reg_idx_t         load_rd,
   output logic [lsu_pkg::XLEN-1:0]  load_data,
   output logic                      interlock,
   output logic                      fwd_store
);

   import lsu_pkg::*;

   logic       pending_q;
   reg_idx_t   rd_q;
   mem_op_e    op_q;
   logic [1:0] addr_q;
   logic       read_accept;
   logic       rd_live;
   logic [7:0] byte_sel;
   logic [15:0] half_sel;

   // ========================================================================
   // Pending load tracking
   // ========================================================================

   assign read_accept = htrans & ~hwrite & hready;

   // Data phase advances only when the bus is ready
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending_q <= 1'b0;
      end else if (hready) begin
         pending_q <= htrans & ~hwrite;
      end
   end

   always_ff @(posedge clk) begin
      if (read_accept) begin
         rd_q   <= rd;
         op_q   <= mem_op;
         addr_q <= addr_lo;
      end
   end

   // ========================================================================
   // Extraction and write-back
   // ========================================================================

   assign byte_sel = hrdata[{addr_q, 3'b000} +: 8];
   assign half_sel = addr_q[1] ? hrdata[31:16] : hrdata[15:0];

   always_comb begin
      case (op_q)
         MEM_LB:  load_data = {{24{byte_sel[7]}}, byte_sel};
         MEM_LBU: load_data = {24'h0, byte_sel};
         MEM_LH:  load_data = {{16{half_sel[15]}}, half_sel};
         MEM_LHU: load_data = {16'h0, half_sel};
         default: load_data = hrdata;
      endcase
   end

   assign load_we = pending_q & hready;
   assign load_rd = rd_q;

   // ========================================================================
   // Hazards against the presented op
   // ========================================================================

   // x0 never carries a result, so it never blocks or forwards
   assign rd_live = pending_q & (rd_q != '0);

   assign interlock = rd_live & (rd_q == rs1);
   assign fwd_store = rd_live & (rd_q == rs2) &
                      (mem_op == MEM_SB || mem_op == MEM_SH || mem_op == MEM_SW);

endmodule

// File: design/lsu_core.sv
// Load/store unit top level

`timescale 1ns/1ps

module lsu_core #(
   parameter int NUM_REGS = 32
) (
   input  logic                      clk,
   input  logic                      rst_n,

   // Issuer side
   input  logic                      op_valid,
   input  lsu_pkg::mem_op_e          mem_op,
   input  lsu_pkg::reg_idx_t         rs1,
   input  lsu_pkg::reg_idx_t         rs2,
   input  lsu_pkg::reg_idx_t         rd,
   input  logic [11:0]               imm12,
   output logic                      stall,

   // ALU write-back
   input  logic                      wb_en,
   input  lsu_pkg::reg_idx_t         wb_rd,
   input  logic [lsu_pkg::XLEN-1:0]  wb_data,

   // AHB-Lite data bus
   output logic [lsu_pkg::XLEN-1:0]  haddr,
   output lsu_pkg::hsize_e           hsize,
   output logic                      htrans,
   output logic                      hwrite,
   output logic [lsu_pkg::XLEN-1:0]  hwdata,
   input  logic [lsu_pkg::XLEN-1:0]  hrdata,
   input  logic                      hready
);

   import lsu_pkg::*;

   logic [XLEN-1:0] rf_rdata_a;
   logic [XLEN-1:0] rf_rdata_b;
   logic            load_we;
   reg_idx_t        load_rd;
   logic [XLEN-1:0] load_data;
   logic            interlock;
   logic            fwd_store;

   // Issuer holds its op on either cause
   assign stall = interlock | ~hready;

   regfile #(
      .NUM_REGS (NUM_REGS)
   ) regfile_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .raddr_a (rs1),
      .raddr_b (rs2),
      .we1     (wb_en),
      .waddr1  (wb_rd),
      .wdata1  (wb_data),
      .we2     (load_we),
      .waddr2  (load_rd),
      .wdata2  (load_data),
      .rdata_a (rf_rdata_a),
      .rdata_b (rf_rdata_b)
   );

   lsu_request lsu_request_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .op_valid   (op_valid),
      .interlock  (interlock),
      .mem_op     (mem_op),
      .imm12      (imm12),
      .base_data  (rf_rdata_a),
      .store_data (rf_rdata_b),
      .load_data  (load_data),
      .fwd_store  (fwd_store),
      .hready     (hready),
      .haddr      (haddr),
      .hsize      (hsize),
      .htrans     (htrans),
      .hwrite     (hwrite),
      .hwdata     (hwdata)
   );

   lsu_load_return lsu_load_return_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hready    (hready),
      .mem_op    (mem_op),
      .rd        (rd),
      .rs1       (rs1),
      .rs2       (rs2),
      .addr_lo   (haddr[1:0]),
      .hrdata    (hrdata),
      .load_we   (load_we),
      .load_rd   (load_rd),
      .load_data (load_data),
      .interlock (interlock),
      .fwd_store (fwd_store)
   );

endmodule

// File: verif/tb_data_mem.sv
// Behavioral AHB-Lite slave memory

`timescale 1ns/1ps

module tb_data_mem #(
   parameter int WORDS = 256
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wait_en,
   input  logic [31:0] haddr,
   input  logic [2:0]  hsize,
   input  logic        htrans,
   input  logic        hwrite,
   input  logic [31:0] hwdata,
   output logic [31:0] hrdata,
   output logic        hready
);

   localparam int AW = $clog2(WORDS);

   logic [31:0] mem [WORDS];
   logic        dp_active;
   logic        dp_write;
   logic [31:0] dp_addr;
   logic [2:0]  dp_size;
   logic        next_active;
   logic [3:0]  lanes;

   // Background fill, each word carries its own byte address
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'h5a5a_0000 ^ 32'(i * 4);
      end
   end

   assign next_active = hready ? htrans : dp_active;
   assign hrdata      = mem[dp_addr[AW+1:2]];

   always_comb begin
      case (dp_size)
         3'd0:    lanes = 4'b0001 << dp_addr[1:0];
         3'd1:    lanes = dp_addr[1] ? 4'b1100 : 4'b0011;
         default: lanes = 4'b1111;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_active <= 1'b0;
         dp_write  <= 1'b0;
         dp_addr   <= '0;
         dp_size   <= '0;
         hready    <= 1'b1;
      end else begin
         if (hready) begin
            dp_active <= htrans;
         end
         if (hready && htrans) begin
            dp_addr  <= haddr;
            dp_size  <= hsize;
            dp_write <= hwrite;
         end
         // Wait states only ever stretch a real data phase
         hready <= (next_active && wait_en) ? (($urandom % 4) != 0) : 1'b1;
      end
   end

   // Store lanes land at the end of the data phase
   always @(posedge clk) begin
      if (rst_n && dp_active && dp_write && hready) begin
         for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
               mem[dp_addr[AW+1:2]][8*b +: 8] <= hwdata[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: verif/tb_lsu_core.sv
// Load/store unit testbench

`timescale 1ns/1ps

module tb_lsu_core;

   import lsu_pkg::*;

   localparam int          CLK_PERIOD  = 20;
   localparam int          ITEM_CYCLES = 40;
   localparam int          NUM_ITEMS   = 2 * (4 + 6 + 13 * 2 + 4 + 4 * 2);
   localparam logic [31:0] LOAD_BASE   = 32'h0000_0080;
   localparam logic [31:0] STORE_BASE  = 32'h0000_0200;

   logic            clk;
   logic            rst_n;
   logic            op_valid;
   mem_op_e         mem_op;
   reg_idx_t        rs1;
   reg_idx_t        rs2;
   reg_idx_t        rd;
   logic [11:0]     imm12;
   logic            stall;
   logic            wb_en;
   reg_idx_t        wb_rd;
   logic [XLEN-1:0] wb_data;
   logic [XLEN-1:0] haddr;
   hsize_e          hsize;
   logic            htrans;
   logic            hwrite;
   logic [XLEN-1:0] hwdata;
   logic [XLEN-1:0] hrdata;
   logic            hready;
   logic            wait_en;

   string           test_name;
   int              errors;
   int              test_errors;
   int              tests_run;
   int              tests_clean;
   logic            wdata_due;
   logic [31:0]     wdata_exp;
   logic [31:0]     preset [64];
   mem_op_e         load_ops [5] = '{MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};

   lsu_core #(
      .NUM_REGS (32)
   ) dut_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .op_valid (op_valid),
      .mem_op   (mem_op),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .imm12    (imm12),
      .stall    (stall),
      .wb_en    (wb_en),
      .wb_rd    (wb_rd),
      .wb_data  (wb_data),
      .haddr    (haddr),
      .hsize    (hsize),
      .htrans   (htrans),
      .hwrite   (hwrite),
      .hwdata   (hwdata),
      .hrdata   (hrdata),
      .hready   (hready)
   );

   tb_data_mem mem_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .wait_en (wait_en),
      .haddr   (haddr),
      .hsize   (hsize),
      .htrans  (htrans),
      .hwrite  (hwrite),
      .hwdata  (hwdata),
      .hrdata  (hrdata),
      .hready  (hready)
   );

   // ========================================================================
   // Reference rules
   // ========================================================================

   function automatic logic is_store(mem_op_e op);
      return op inside {MEM_SB, MEM_SH, MEM_SW};
   endfunction

   function automatic hsize_e size_of(mem_op_e op);
      case (op)
         MEM_LB, MEM_LBU, MEM_SB: return HSIZE_BYTE;
         MEM_LH, MEM_LHU, MEM_SH: return HSIZE_HALF;
         default:                 return HSIZE_WORD;
      endcase
   endfunction

   // Low source bits moved up to the addressed lane
   function automatic logic [31:0] lane_place(mem_op_e op, logic [1:0] lo, logic [31:0] v);
      case (size_of(op))
         HSIZE_BYTE: return 32'(v[7:0]) << (8 * lo);
         HSIZE_HALF: return 32'(v[15:0]) << (16 * lo[1]);
         default:    return v;
      endcase
   endfunction

   function automatic logic [31:0] extend(mem_op_e op, logic [1:0] lo, logic [31:0] word);
      logic [31:0] sh;
      sh = word >> (8 * lo);
      case (op)
         MEM_LB:  return {{24{sh[7]}}, sh[7:0]};
         MEM_LBU: return {24'h0, sh[7:0]};
         MEM_LH:  return {{16{sh[15]}}, sh[15:0]};
         MEM_LHU: return {16'h0, sh[15:0]};
         default: return word;
      endcase
   endfunction

   function automatic logic [31:0] preset_at(logic [31:0] addr);
      return preset[addr[7:2]];
   endfunction

   // ========================================================================
   // Checks and drivers
   // ========================================================================

   task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
      assert (act === exp) else begin
         $display("Fail %s: %s expected %h, actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic check_true(logic cond, string msg);
      assert (cond === 1'b1) else begin
         $display("Error in %s: %s", test_name, msg);
         test_errors++;
      end
   endtask

   // Samples mid-cycle; a store's hwdata is due in the cycle after acceptance
   task automatic tick();
      @(negedge clk);
      check_true(hready || stall, "stall stayed low during a wait state");
      if (wdata_due) begin
         check_value("hwdata", wdata_exp, hwdata);
         wdata_due = 1'b0;
      end
   endtask

   task automatic idle();
      @(posedge clk);
      #1;
      op_valid = 1'b0;
      wb_en    = 1'b0;
      tick();
   endtask

   task automatic set_reg(reg_idx_t r, logic [31:0] v);
      @(posedge clk);
      #1;
      op_valid = 1'b0;
      wb_en    = 1'b1;
      wb_rd    = r;
      wb_data  = v;
      tick();
   endtask

   task automatic issue(mem_op_e op, reg_idx_t base, reg_idx_t src, reg_idx_t dst,
                        logic [11:0] imm, logic [31:0] exp_addr, logic [31:0] exp_src,
                        output int stalls);
      logic [31:0] held_addr;
      logic [3:0]  held_ctl;
      logic        was_waiting;
      @(posedge clk);
      #1;
      wb_en       = 1'b0;
      op_valid    = 1'b1;
      mem_op      = op;
      rs1         = base;
      rs2         = src;
      rd          = dst;
      imm12       = imm;
      stalls      = 0;
      was_waiting = 1'b0;
      held_addr   = '0;
      held_ctl    = '0;
      tick();
      while (stall) begin
         stalls++;
         // Stall with the bus ready can only be the interlock
         if (hready) begin
            check_true(!htrans, "transfer put out during an interlock");
         end
         if (was_waiting && !hready) begin
            check_value("held haddr", held_addr, haddr);
            check_value("held hsize/hwrite", 32'(held_ctl), 32'({hsize, hwrite}));
         end
         was_waiting = !hready;
         held_addr   = haddr;
         held_ctl    = {hsize, hwrite};
         tick();
      end
      check_true(htrans, "no transfer on an accepted op");
      check_value("haddr", exp_addr, haddr);
      check_value("hsize", 32'(size_of(op)), 32'(hsize));
      check_value("hwrite", 32'(is_store(op)), 32'(hwrite));
      if (is_store(op)) begin
         wdata_due = 1'b1;
         wdata_exp = lane_place(op, exp_addr[1:0], exp_src);
      end
   endtask

   task automatic start_test(string name);
      test_name   = wait_en ? {name, " (wait states)"} : name;
      test_errors = 0;
   endtask

   // Drain the last data phase before the next test touches registers
   task automatic end_test();
      idle();
      while (!hready) begin
         idle();
      end
      tests_run++;
      errors += test_errors;
      if (test_errors == 0) begin
         tests_clean++;
      end
      $display("%s: %0d errors", test_name, test_errors);
   endtask

   // Load into x7, then store x7, either back to back or one cycle apart
   task automatic load_then_store(mem_op_e op, int lo, logic back_to_back);
      logic [31:0] exp;
      logic [31:0] addr;
      int          disp;
      int          s;
      disp = 4 * int'($urandom % 32) - 64 + lo;
      addr = LOAD_BASE + disp;
      exp  = extend(op, addr[1:0], preset_at(addr));
      set_reg(7, ~exp);
      issue(op, 1, 0, 7, 12'(disp), addr, '0, s);
      if (!back_to_back) begin
         idle();
      end
      issue(MEM_SW, 2, 7, 0, 12'(64), STORE_BASE + 64, exp, s);
      if (back_to_back && !wait_en) begin
         check_value("forwarded store stall cycles", 0, s);
      end
   endtask

   // ========================================================================
   // Tests
   // ========================================================================

   task automatic run_word_store();
      logic [31:0] v;
      int          s;
      start_test("word_store");
      set_reg(2, STORE_BASE);
      for (int k = 0; k < 4; k++) begin
         v = $urandom;
         set_reg(3, v);
         issue(MEM_SW, 2, 3, 0, 12'(4 * k), STORE_BASE + 4 * k, v, s);
      end
      end_test();
   endtask

   task automatic run_store_lanes();
      logic [31:0] v;
      int          s;
      start_test("store_lanes");
      set_reg(2, STORE_BASE);
      for (int off = 0; off < 4; off++) begin
         v = $urandom;
         set_reg(3, v);
         issue(MEM_SB, 2, 3, 0, 12'(16 + off), STORE_BASE + 16 + off, v, s);
      end
      for (int off = 0; off < 4; off += 2) begin
         v = $urandom;
         set_reg(3, v);
         issue(MEM_SH, 2, 3, 0, 12'(32 + off), STORE_BASE + 32 + off, v, s);
      end
      end_test();
   endtask

   task automatic run_loads();
      start_test("load_extend");
      set_reg(1, LOAD_BASE);
      set_reg(2, STORE_BASE);
      foreach (load_ops[i]) begin
         for (int off = 0; off < 4; off += (1 << size_of(load_ops[i]))) begin
            load_then_store(load_ops[i], off, 1'b0);
         end
      end
      end_test();
   endtask

   task automatic run_interlock();
      int s;
      start_test("interlock");
      set_reg(1, LOAD_BASE);
      // Dependent op uses the loaded word as its base
      issue(MEM_LW, 1, 0, 6, 12'(8), LOAD_BASE + 8, '0, s);
      issue(MEM_LW, 6, 0, 0, 12'(4), preset_at(LOAD_BASE + 8) + 4, '0, s);
      if (wait_en) begin
         check_true(s >= 1, "dependent op was not held");
      end else begin
         check_value("interlock stall cycles", 1, s);
      end
      // x0 destination never blocks
      issue(MEM_LW, 1, 0, 0, 12'(12), LOAD_BASE + 12, '0, s);
      issue(MEM_LW, 0, 0, 0, 12'(16), 32'h10, '0, s);
      if (!wait_en) begin
         check_value("x0 stall cycles", 0, s);
      end
      end_test();
   endtask

   task automatic run_forwarding();
      start_test("store_forwarding");
      set_reg(1, LOAD_BASE);
      set_reg(2, STORE_BASE);
      load_then_store(MEM_LW, 0, 1'b1);
      load_then_store(MEM_LH, 2, 1'b1);
      load_then_store(MEM_LBU, 3, 1'b1);
      load_then_store(MEM_LB, 1, 1'b1);
      end_test();
   endtask

   // ========================================================================
   // Clock, sequence and watchdog
   // ========================================================================

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      void'($urandom(68183));
      rst_n       = 1'b0;
      op_valid    = 1'b0;
      mem_op      = MEM_LW;
      rs1         = '0;
      rs2         = '0;
      rd          = '0;
      imm12       = '0;
      wb_en       = 1'b0;
      wb_rd       = '0;
      wb_data     = '0;
      wait_en     = 1'b0;
      errors      = 0;
      tests_run   = 0;
      tests_clean = 0;
      wdata_due   = 1'b0;
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int i = 0; i < 64; i++) begin
         preset[i]     = $urandom;
         mem_i.mem[i]  = preset[i];
      end
      for (int pass = 0; pass < 2; pass++) begin
         #1 wait_en = (pass == 1);
         run_word_store();
         run_store_lanes();
         run_loads();
         run_interlock();
         run_forwarding();
      end
      $display("Tests run %0d, clean %0d, total errors %0d", tests_run, tests_clean, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   initial begin
      #(CLK_PERIOD * ITEM_CYCLES * NUM_ITEMS);
      $display("Timeout: tests did not finish within %0d cycles", ITEM_CYCLES * NUM_ITEMS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: lsu_core.f
common/lsu_pkg.sv
design/regfile.sv
lsu/lsu_request.sv
lsu/lsu_load_return.sv
design/lsu_core.sv
verif/tb_data_mem.sv
verif/tb_lsu_core.sv

// File: Bender.yml
package:
  name: lsu_core

sources:
  - common/lsu_pkg.sv
  - design/regfile.sv
  - lsu/lsu_request.sv
  - lsu/lsu_load_return.sv
  - design/lsu_core.sv
  - target: simulation
    files:
      - verif/tb_data_mem.sv
      - verif/tb_lsu_core.sv
